// ==== hw/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'haaaaa000

// entries between fetch and decode
`define FETCH_QUEUE_DEPTH 8

// one instruction line and one memory beat
`define FETCH_LINE_BITS 256
`define FETCH_BEAT_BITS 64

// beats that make up one line
`define FETCH_BEATS_PER_LINE 4

`endif

// ==== hw/fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

    // one buffered instruction line
    typedef logic [`FETCH_LINE_BITS-1:0] line_t;

    // one burst memory beat
    typedef logic [`FETCH_BEAT_BITS-1:0] beat_t;

    // queue payload, one fetched instruction
    typedef struct packed {
        logic [63:0] order;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    // functional unit class of an instruction
    typedef enum logic [2:0] {
        none = 3'd0,
        alu  = 3'd1,
        br   = 3'd2,
        mem  = 3'd3,
        mul  = 3'd4
    } op_class_t;

    // decode result
    typedef struct packed {
        op_class_t  op_class;
        logic [4:0] rd_addr;
        logic       writes_rd;
    } decoded_t;

endpackage

// ==== hw/line_fill_if.sv ====
`timescale 1ns/100ps

interface line_fill_if;
    import fetch_pkg::*;

    // request is a single pulse, done comes back once per request
    logic        fill_req;
    logic [31:0] fill_addr;
    line_t       fill_line;
    logic        fill_done;

    modport requester (
        output fill_req,
        output fill_addr,
        input  fill_line,
        input  fill_done
    );

    modport filler (
        input  fill_req,
        input  fill_addr,
        output fill_line,
        output fill_done
    );
endinterface

// ==== hw/line_assembler.sv ====
`timescale 1ns/100ps
`include "fetch_settings.svh"

module line_assembler (
    input  logic             clk,
    input  logic             rst,
    line_fill_if.filler      fill,
    input  logic             bmem_ready_i,
    input  fetch_pkg::beat_t bmem_rdata_i,
    input  logic             bmem_rvalid_i,
    output logic [31:0]      bmem_addr_o,
    output logic             bmem_read_o
);
    import fetch_pkg::*;

    localparam int BEAT_IDX_BITS = $clog2(`FETCH_BEATS_PER_LINE);
    localparam int LAST_BEAT = `FETCH_BEATS_PER_LINE - 1;

    logic                     pending;
    logic                     busy;
    logic [BEAT_IDX_BITS-1:0] beat_cnt;
    logic [31:0]              addr_q;
    line_t                    line_q;
    logic                     beat_in;
    logic                     last_beat;

    // read goes out as soon as memory can take it
    assign bmem_read_o = pending && bmem_ready_i;
    assign bmem_addr_o = addr_q;

    assign beat_in = busy && bmem_rvalid_i;
    assign last_beat = beat_in && (beat_cnt == BEAT_IDX_BITS'(LAST_BEAT));

    assign fill.fill_line = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            busy <= 1'b0;
            beat_cnt <= '0;
            fill.fill_done <= 1'b0;
        end else begin
            // line is complete one cycle after the last beat
            fill.fill_done <= last_beat;

            if (fill.fill_req) begin
                pending <= 1'b1;
            end else if (bmem_read_o) begin
                pending <= 1'b0;
            end

            if (bmem_read_o) begin
                busy <= 1'b1;
            end else if (last_beat) begin
                busy <= 1'b0;
            end

            if (beat_in) begin
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // address and beat slots, lowest address first
    always_ff @(posedge clk) begin
        if (fill.fill_req) begin
            addr_q <= fill.fill_addr;
        end
        if (beat_in) begin
            line_q[beat_cnt*`FETCH_BEAT_BITS +: `FETCH_BEAT_BITS] <= bmem_rdata_i;
        end
    end
endmodule

// ==== hw/fetch_control.sv ====
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_control (
    input  logic                    clk,
    input  logic                    rst,
    line_fill_if.requester          fill,
    input  logic                    full_i,
    output logic                    enq_o,
    output fetch_pkg::fetch_entry_t enq_data_o
);
    import fetch_pkg::*;

    // byte offset inside a line, and the word index within it
    localparam int OFFSET_BITS = $clog2(`FETCH_LINE_BITS / 8);
    localparam int TAG_BITS = 32 - OFFSET_BITS;
    localparam int WORD_SEL_BITS = OFFSET_BITS - 2;

    logic [31:0]              pc;
    logic [63:0]              order;
    line_t                    buf_line;
    logic [TAG_BITS-1:0]      buf_tag;
    logic                     buf_valid;
    logic                     waiting;
    logic                     hit;
    logic                     start_fill;
    logic [WORD_SEL_BITS-1:0] word_sel;

    assign hit = buf_valid && (buf_tag == pc[31:OFFSET_BITS]);
    assign word_sel = pc[OFFSET_BITS-1:2];

    // request once per miss, then wait for the line
    assign start_fill = !hit && !waiting;

    // enqueue straight from the line buffer
    assign enq_o = hit && !full_i;

    always_comb begin
        enq_data_o.order = order;
        enq_data_o.pc = pc;
        enq_data_o.inst = buf_line[word_sel*32 +: 32];
    end

    // strictly sequential fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FETCH_RESET_PC;
            order <= '0;
        end else if (enq_o) begin
            pc <= pc + 32'd4;
            order <= order + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill.fill_req <= 1'b0;
            waiting <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            fill.fill_req <= start_fill;
            if (fill.fill_done) begin
                waiting <= 1'b0;
                buf_valid <= 1'b1;
            end else if (start_fill) begin
                waiting <= 1'b1;
            end
        end
    end

    // line-aligned request address and the buffered line
    always_ff @(posedge clk) begin
        if (start_fill) begin
            fill.fill_addr <= {pc[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
        if (fill.fill_done) begin
            buf_line <= fill.fill_line;
            buf_tag <= fill.fill_addr[31:OFFSET_BITS];
        end
    end
endmodule

// ==== hw/fifo_queue.sv ====
`timescale 1ns/100ps

module fifo_queue #(
    parameter type T = logic,
    parameter int  DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic enq_i,
    input  T     data_i,
    output logic full_o,
    input  logic deq_i,
    output T     data_o,
    output logic empty_o
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    T                    entries [DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [CNT_BITS-1:0] count;
    logic                do_enq;
    logic                do_deq;

    assign full_o = (count == CNT_BITS'(DEPTH));
    assign empty_o = (count == '0);
    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && !empty_o;

    // head is visible without delay
    assign data_o = entries[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= (tail == PTR_BITS'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (do_deq) begin
                head <= (head == PTR_BITS'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            entries[tail] <= data_i;
        end
    end
endmodule

// ==== hw/decode_class.sv ====
`timescale 1ns/100ps

module decode_class (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    empty_i,
    input  fetch_pkg::fetch_entry_t head_i,
    input  logic                    issue_stall_i,
    output logic                    deq_o,
    output logic                    inst_valid_o,
    output fetch_pkg::fetch_entry_t entry_o,
    output fetch_pkg::decoded_t     decoded_o
);
    import fetch_pkg::*;

    // rv32 major opcodes
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_REG   = 7'b0110011;
    localparam logic [6:0] OPC_BR    = 7'b1100011;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    function automatic decoded_t classify(input logic [31:0] inst);
        decoded_t   d;
        logic [6:0] opcode;
        opcode = inst[6:0];
        d.rd_addr = inst[11:7];
        d.writes_rd = 1'b0;
        d.op_class = none;
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_IMM: begin
                d.op_class = alu;
                d.writes_rd = 1'b1;
            end
            // funct7 of 1 selects the multiply group
            OPC_REG: begin
                d.op_class = (inst[31:25] == 7'd1) ? mul : alu;
                d.writes_rd = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                d.op_class = br;
                d.writes_rd = 1'b1;
            end
            OPC_BR:    d.op_class = br;
            OPC_LOAD: begin
                d.op_class = mem;
                d.writes_rd = 1'b1;
            end
            OPC_STORE: d.op_class = mem;
            default:   d.op_class = none;
        endcase
        // x0 never takes a write
        if (d.rd_addr == 5'd0) begin
            d.writes_rd = 1'b0;
        end
        return d;
    endfunction

    assign deq_o = !empty_i && !issue_stall_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= deq_o;
        end
    end

    always_ff @(posedge clk) begin
        if (deq_o) begin
            entry_o <= head_i;
            decoded_o <= classify(head_i.inst);
        end
    end
endmodule

// ==== hw/fetch_front_end.sv ====
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_front_end (
    input  logic                        clk,
    input  logic                        rst,

    // burst memory, read only
    output logic [31:0]                 bmem_addr_o,
    output logic                        bmem_read_o,
    input  logic                        bmem_ready_i,
    input  logic [`FETCH_BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                        bmem_rvalid_i,

    input  logic                        issue_stall_i,

    // decoded instruction
    output logic                        inst_valid_o,
    output logic [31:0]                 inst_o,
    output logic [31:0]                 pc_o,
    output logic [63:0]                 order_o,
    output fetch_pkg::op_class_t        op_class_o,
    output logic [4:0]                  rd_addr_o,
    output logic                        writes_rd_o
);
    import fetch_pkg::*;

    line_fill_if  fill_bus ();

    logic         enq;
    logic         deq;
    logic         q_full;
    logic         q_empty;
    fetch_entry_t enq_data;
    fetch_entry_t head_data;
    fetch_entry_t out_entry;
    decoded_t     out_decoded;

    line_assembler assembler_i (
        .clk           (clk),
        .rst           (rst),
        .fill          (fill_bus.filler),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o)
    );

    fetch_control fetch_i (
        .clk        (clk),
        .rst        (rst),
        .fill       (fill_bus.requester),
        .full_i     (q_full),
        .enq_o      (enq),
        .enq_data_o (enq_data)
    );

    fifo_queue #(
        .T     (fetch_entry_t),
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) queue_i (
        .clk     (clk),
        .rst     (rst),
        .enq_i   (enq),
        .data_i  (enq_data),
        .full_o  (q_full),
        .deq_i   (deq),
        .data_o  (head_data),
        .empty_o (q_empty)
    );

    decode_class decode_i (
        .clk           (clk),
        .rst           (rst),
        .empty_i       (q_empty),
        .head_i        (head_data),
        .issue_stall_i (issue_stall_i),
        .deq_o         (deq),
        .inst_valid_o  (inst_valid_o),
        .entry_o       (out_entry),
        .decoded_o     (out_decoded)
    );

    assign inst_o = out_entry.inst;
    assign pc_o = out_entry.pc;
    assign order_o = out_entry.order;
    assign op_class_o = out_decoded.op_class;
    assign rd_addr_o = out_decoded.rd_addr;
    assign writes_rd_o = out_decoded.writes_rd;
endmodule

// ==== tb/bmem_model.sv ====
`timescale 1ns/100ps
`include "fetch_settings.svh"

module bmem_model #(
    parameter int SEED = 0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      bmem_addr_i,
    input  logic             bmem_read_i,
    output logic             bmem_ready_o,
    output fetch_pkg::beat_t bmem_rdata_o,
    output logic             bmem_rvalid_o
);
    import fetch_pkg::*;

    localparam int BEATS = `FETCH_BEATS_PER_LINE;
    localparam int BEAT_BYTES = `FETCH_BEAT_BITS / 8;

    int          seed;
    logic        read_seen;
    logic [31:0] addr_seen;
    logic [31:0] base;
    int          beat_idx;
    logic [31:0] rnd;

    // instruction image, a fixed function of the word address
    function automatic logic [31:0] image_word(input logic [31:0] addr);
        logic [31:0] mix;
        logic [31:0] word;
        int          sel;
        mix = (addr * 32'h9e37_79b1) ^ (addr >> 13) ^ 32'h2545_f491;
        word = mix;
        sel = int'(mix[31:20] % 12'd11);
        case (sel)
            0: word[6:0] = 7'h37;
            1: word[6:0] = 7'h17;
            2: word[6:0] = 7'h13;
            3: begin
                word[6:0] = 7'h33;
                word[31:25] = {1'b0, mix[30], 5'b0};
            end
            // multiply group
            4: begin
                word[6:0] = 7'h33;
                word[31:25] = 7'h01;
            end
            5: word[6:0] = 7'h63;
            6: word[6:0] = 7'h6f;
            7: word[6:0] = 7'h67;
            8: word[6:0] = 7'h03;
            9: word[6:0] = 7'h23;
            // custom opcode, decodes to no class
            default: word[6:0] = 7'h0b;
        endcase
        return word;
    endfunction

    initial begin
        seed = SEED;
        bmem_ready_o = 1'b0;
        bmem_rdata_o = '0;
        bmem_rvalid_o = 1'b0;
        read_seen = 1'b0;
        addr_seen = '0;
        base = '0;
        beat_idx = BEATS;
    end

    // requests are taken where the bus is stable
    always @(negedge clk) begin
        read_seen = bmem_read_i;
        addr_seen = bmem_addr_i;
    end

    always @(posedge clk) begin
        #1;
        if (rst) begin
            bmem_ready_o = 1'b0;
            bmem_rvalid_o = 1'b0;
            bmem_rdata_o = '0;
            beat_idx = BEATS;
        end else begin
            if (read_seen) begin
                base = addr_seen;
                beat_idx = 0;
            end
            rnd = $random(seed);
            // about one cycle in four leaves a gap between beats
            if (beat_idx < BEATS && rnd[1:0] != 2'd0) begin
                bmem_rdata_o = {image_word(base + 32'(beat_idx * BEAT_BYTES) + 32'd4),
                                image_word(base + 32'(beat_idx * BEAT_BYTES))};
                bmem_rvalid_o = 1'b1;
                beat_idx++;
            end else begin
                bmem_rdata_o = '0;
                bmem_rvalid_o = 1'b0;
            end
            bmem_ready_o = (rnd[4:2] != 3'd0);
        end
    end
endmodule

// ==== tb/tb_fetch_front_end.sv ====
`timescale 1ns/100ps
`include "fetch_settings.svh"

module tb_fetch_front_end;
    import fetch_pkg::*;

    localparam int NUM_CHECKS = 300;
    localparam int RUN_LIMIT = 20000;
    localparam int IDLE_LIMIT = 2000;
    localparam int LINE_BYTES = `FETCH_LINE_BITS / 8;

    logic        clk;
    logic        rst;
    logic [31:0] bmem_addr;
    logic        bmem_read;
    logic        bmem_ready;
    beat_t       bmem_rdata;
    logic        bmem_rvalid;
    logic        issue_stall;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [63:0] order;
    op_class_t   op_class;
    logic [4:0]  rd_addr;
    logic        writes_rd;

    int          seed;
    int          checked;
    int          beats_left;
    logic [31:0] exp_pc;
    logic [63:0] exp_order;
    logic [31:0] exp_line;
    logic        prev_rst;

    fetch_front_end dut_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .issue_stall_i (issue_stall),
        .inst_valid_o  (inst_valid),
        .inst_o        (inst),
        .pc_o          (pc),
        .order_o       (order),
        .op_class_o    (op_class),
        .rd_addr_o     (rd_addr),
        .writes_rd_o   (writes_rd)
    );

    bmem_model #(
        .SEED (32'h8544_35bb)
    ) mem_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    task automatic report_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Mismatch %s expected %h actual %h", name, expected, actual);
        report_failure();
    endtask

    // reference classification by major opcode
    function automatic op_class_t expected_class(input logic [31:0] word);
        logic [6:0] opcode;
        opcode = word[6:0];
        if (opcode inside {7'h37, 7'h17, 7'h13}) return alu;
        if (opcode == 7'h33) return (word[31:25] == 7'h01) ? mul : alu;
        if (opcode inside {7'h63, 7'h6f, 7'h67}) return br;
        if (opcode inside {7'h03, 7'h23}) return mem;
        return none;
    endfunction

    function automatic logic expected_writes(input logic [31:0] word);
        logic has_rd;
        has_rd = word[6:0] inside {7'h37, 7'h17, 7'h13, 7'h33, 7'h6f, 7'h67, 7'h03};
        return has_rd && (word[11:7] != 5'd0);
    endfunction

    task automatic check_output();
        logic [31:0] exp_inst;
        exp_inst = mem_i.image_word(exp_pc);
        assert (pc == exp_pc) else report_mismatch("pc_o", exp_pc, pc);
        assert (order == exp_order) else report_mismatch("order_o", exp_order, order);
        assert (inst == exp_inst) else report_mismatch("inst_o", exp_inst, inst);
        assert (op_class == expected_class(exp_inst))
            else report_mismatch("op_class_o", expected_class(exp_inst), op_class);
        assert (rd_addr == exp_inst[11:7])
            else report_mismatch("rd_addr_o", exp_inst[11:7], rd_addr);
        assert (writes_rd == expected_writes(exp_inst))
            else report_mismatch("writes_rd_o", expected_writes(exp_inst), writes_rd);
        exp_pc += 32'd4;
        exp_order += 64'd1;
        checked++;
    endtask

    assert property (@(posedge clk) disable iff (rst) bmem_read |-> bmem_ready)
        else begin
            $display("read issued while bmem_ready_i was low");
            report_failure();
        end

    assert property (@(posedge clk) disable iff (rst) bmem_read |-> (bmem_addr[4:0] == 5'd0))
        else report_mismatch("bmem_addr_o[4:0]", 64'd0, $sampled(bmem_addr[4:0]));

    // a held issue stall blocks the next output
    assert property (@(posedge clk) disable iff (rst) inst_valid |-> !$past(issue_stall))
        else begin
            $display("output valid after a cycle with issue stall held");
            report_failure();
        end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // outputs and the memory bus are checked mid cycle
    always @(negedge clk) begin
        if (rst || prev_rst) begin
            assert (!bmem_read) else report_mismatch("bmem_read_o", 64'd0, bmem_read);
            assert (!inst_valid) else report_mismatch("inst_valid_o", 64'd0, inst_valid);
        end
        if (!rst) begin
            if (bmem_rvalid) begin
                assert (beats_left > 0) else begin
                    $display("memory beat arrived with no read outstanding");
                    report_failure();
                end
                beats_left--;
            end
            if (bmem_read) begin
                assert (beats_left == 0) else begin
                    $display("read issued while a previous fill still lacks beats");
                    report_failure();
                end
                assert (bmem_addr == exp_line)
                    else report_mismatch("bmem_addr_o", exp_line, bmem_addr);
                exp_line += 32'(LINE_BYTES);
                beats_left = `FETCH_BEATS_PER_LINE;
            end
            if (inst_valid) begin
                check_output();
            end
        end
        prev_rst = rst;
    end

    initial begin
        int          cycles;
        int          idle;
        logic [31:0] rnd;
        seed = 32'h8544_35bb;
        rst = 1'b1;
        issue_stall = 1'b1;
        checked = 0;
        beats_left = 0;
        prev_rst = 1'b1;
        exp_pc = `FETCH_RESET_PC;
        exp_order = '0;
        exp_line = `FETCH_RESET_PC & ~(32'(LINE_BYTES) - 32'd1);
        cycles = 0;
        idle = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        while (checked < NUM_CHECKS && cycles < RUN_LIMIT && idle < IDLE_LIMIT) begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            // free running, long stall runs that fill the queue, then mixed
            case ((cycles / 48) % 3)
                0:       issue_stall = (rnd[2:0] == 3'd0);
                1:       issue_stall = (rnd[2:0] != 3'd0);
                default: issue_stall = rnd[0];
            endcase
            idle = inst_valid ? 0 : idle + 1;
            cycles++;
        end
        if (checked < NUM_CHECKS) begin
            $display("timeout after %0d cycles, %0d of %0d instructions checked",
                     cycles, checked, NUM_CHECKS);
            report_failure();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end
endmodule

// ==== all.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/line_fill_if.sv
hw/line_assembler.sv
hw/fetch_control.sv
hw/fifo_queue.sv
hw/decode_class.sv
hw/fetch_front_end.sv
tb/bmem_model.sv
tb/tb_fetch_front_end.sv

// ==== Makefile ====
TOP = tb_fetch_front_end
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
